// ==== source/wro_defines.svh ====
// Write-read ordering shim sizing macros shared by packages, RTL and testbench
`ifndef WRO_DEFINES_SVH
`define WRO_DEFINES_SVH

// Number of requests that may be in flight toward memory at once
`define WRO_N_SLOTS 8

// Width of a request address
`define WRO_ADDR_BITS 32

// Width of the address hash used for conflict detection
`define WRO_HASH_BITS 6

// Width of the client metadata carried with each request
`define WRO_MDATA_BITS 16

// Entries in the input request FIFO
`define WRO_FIFO_DEPTH 4

`endif

// ==== source/wro_req_pkg.sv ====
// Request and response field types of the write-read ordering shim
`include "wro_defines.svh"

package wro_req_pkg;

    // Full request address as presented by the client
    typedef logic [`WRO_ADDR_BITS-1:0] t_addr;

    // Address hash, the XOR of consecutive slices of the address
    // The top slice is zero-padded when the address width is not a multiple
    typedef logic [`WRO_HASH_BITS-1:0] t_hash;

    // Client metadata, saved in a slot while the request is at memory
    typedef logic [`WRO_MDATA_BITS-1:0] t_mdata;

    // Slot index that replaces the metadata on the memory side
    typedef logic [$clog2(`WRO_N_SLOTS)-1:0] t_tag;

endpackage

// ==== source/wro_ctrl_pkg.sv ====
// Tracking state types of the write-read ordering shim
`include "wro_defines.svh"

package wro_ctrl_pkg;

    // State of one tracking slot
    // A busy slot remembers whether it holds a read or a write
    typedef enum logic [1:0]
    {
        SLOT_FREE  = 2'd0,
        SLOT_READ  = 2'd1,
        SLOT_WRITE = 2'd2
    } t_slot_state;

    // One bit per tracking slot
    typedef logic [`WRO_N_SLOTS-1:0] t_slot_mask;

    // Input FIFO occupancy, wide enough to hold the full depth
    typedef logic [$clog2(`WRO_FIFO_DEPTH+1)-1:0] t_fifo_count;

endpackage

// ==== source/wro_head_if.sv ====
// Oldest waiting request, offered by the hasher to the slots and issue logic
`timescale 1ns/1ps
`include "wro_defines.svh"

interface wro_head_if;
    import wro_req_pkg::*;

    // Head register contents, valid while head_valid is high
    logic   head_valid;
    logic   head_is_write;
    t_addr  head_addr;
    t_hash  head_hash;
    t_mdata head_mdata;

    // Issue logic consumes the head at the next edge
    // Only ever raised together with head_valid
    logic   take;

    modport source (output head_valid, head_is_write, head_addr, head_hash,
                    head_mdata, input take);

    modport sink (input head_valid, head_is_write, head_addr, head_hash,
                  head_mdata, output take);

    // Slots compare against the head and capture its metadata on insert
    modport observe (input head_hash, head_is_write, head_mdata);

endinterface

// ==== source/wro_slot_if.sv ====
// Control and status between one tracking slot and the issue logic
`timescale 1ns/1ps
`include "wro_defines.svh"

interface wro_slot_if;
    import wro_req_pkg::*;

    // One-cycle pulses from the issue logic
    // insert only hits an idle slot, free only hits a busy one
    logic   insert;
    logic   free;

    // Slot status
    logic   busy;
    logic   conflict;

    // Client metadata held while the request is outstanding
    t_mdata saved_mdata;

    modport slot (input insert, free, output busy, conflict, saved_mdata);

    modport issue (output insert, free, input busy, conflict, saved_mdata);

endinterface

// ==== source/wro_req_hasher.sv ====
// Input request FIFO with address hashing into a registered head
`timescale 1ns/1ps
`include "wro_defines.svh"

module wro_req_hasher
(
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  logic                req_is_write,
    input  wro_req_pkg::t_addr  req_addr,
    input  wro_req_pkg::t_mdata req_mdata,
    output logic                req_almost_full,
    wro_head_if.source          head
);
    import wro_req_pkg::*;
    import wro_ctrl_pkg::*;

    localparam int DEPTH    = `WRO_FIFO_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int HB       = `WRO_HASH_BITS;
    localparam int N_SLICES = (`WRO_ADDR_BITS + HB - 1) / HB;

    // ==================================================================
    // Address hash
    // ==================================================================

    // XOR of consecutive hash-wide slices starting at bit 0
    function automatic t_hash addr_hash(input t_addr addr);
        logic [N_SLICES*HB-1:0] padded;
        t_hash                  h;
        padded = (N_SLICES*HB)'(addr);
        h = '0;
        for (int s = 0; s < N_SLICES; s++)
        begin
            h ^= padded[s*HB +: HB];
        end
        return h;
    endfunction

    // ==================================================================
    // Request FIFO
    // ==================================================================

    logic                fifo_is_write [DEPTH];
    t_addr               fifo_addr     [DEPTH];
    t_mdata              fifo_mdata    [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    t_fifo_count         count;
    logic                pop;

    // The head register refills whenever it is empty or being consumed
    assign pop = (count != '0) && (!head.head_valid || head.take);

    // Leave one entry of slack for a strobe already on its way
    assign req_almost_full = (count >= t_fifo_count'(DEPTH - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (req_valid)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + t_fifo_count'(req_valid) - t_fifo_count'(pop);
        end
    end

    // Storage array, written on every accepted strobe
    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            fifo_is_write[wr_ptr] <= req_is_write;
            fifo_addr[wr_ptr]     <= req_addr;
            fifo_mdata[wr_ptr]    <= req_mdata;
        end
    end

    // ==================================================================
    // Head register
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head.head_valid <= 1'b0;
        end
        else if (!head.head_valid || head.take)
        begin
            head.head_valid <= pop;
        end
    end

    // Payload follows the FIFO front, hashed on the way in
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            head.head_is_write <= fifo_is_write[rd_ptr];
            head.head_addr     <= fifo_addr[rd_ptr];
            head.head_hash     <= addr_hash(fifo_addr[rd_ptr]);
            head.head_mdata    <= fifo_mdata[rd_ptr];
        end
    end

endmodule

// ==== source/wro_slot.sv ====
// One tracking slot holding an outstanding request's hash, kind and metadata
`timescale 1ns/1ps
`include "wro_defines.svh"

module wro_slot
(
    input  logic        clk,
    input  logic        reset,
    wro_head_if.observe head,
    wro_slot_if.slot    ctl
);
    import wro_req_pkg::*;
    import wro_ctrl_pkg::*;

    t_slot_state state;
    t_hash       hash;
    t_mdata      mdata;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= SLOT_FREE;
        end
        else if (ctl.free)
        begin
            state <= SLOT_FREE;
        end
        else if (ctl.insert)
        begin
            state <= head.head_is_write ? SLOT_WRITE : SLOT_READ;
        end
    end

    // Captured alongside the state change on insert
    always_ff @(posedge clk)
    begin
        if (ctl.insert)
        begin
            hash  <= head.head_hash;
            mdata <= head.head_mdata;
        end
    end

    assign ctl.busy        = (state != SLOT_FREE);
    assign ctl.saved_mdata = mdata;

    // Reads may pass reads; any pairing with a write on the same hash must wait
    assign ctl.conflict = ctl.busy && (hash == head.head_hash) &&
                          ((state == SLOT_WRITE) || head.head_is_write);

endmodule

// ==== source/wro_issue.sv ====
// Slot allocation, issue toward memory and response metadata restoration
`timescale 1ns/1ps
`include "wro_defines.svh"

module wro_issue
(
    input  logic                clk,
    input  logic                reset,
    wro_head_if.sink            head,
    wro_slot_if.issue           slots [`WRO_N_SLOTS],
    input  logic                mem_almost_full,
    output logic                mem_req_valid,
    output logic                mem_req_is_write,
    output wro_req_pkg::t_addr  mem_req_addr,
    output wro_req_pkg::t_tag   mem_req_tag,
    input  logic                mem_rsp_valid,
    input  logic                mem_rsp_is_write,
    input  wro_req_pkg::t_tag   mem_rsp_tag,
    output logic                rsp_valid,
    output logic                rsp_is_write,
    output wro_req_pkg::t_mdata rsp_mdata
);
    import wro_req_pkg::*;
    import wro_ctrl_pkg::*;

    t_slot_mask busy_mask;
    t_slot_mask conflict_mask;
    t_mdata     saved_mdata [`WRO_N_SLOTS];
    t_tag       alloc_idx;
    logic       alloc_ok;
    logic       issue_now;

    // ==================================================================
    // Slot status gather and pulse fan-out
    // ==================================================================

    for (genvar i = 0; i < `WRO_N_SLOTS; i++)
    begin : g_slot
        assign busy_mask[i]     = slots[i].busy;
        assign conflict_mask[i] = slots[i].conflict;
        assign saved_mdata[i]   = slots[i].saved_mdata;

        // The chosen slot records the head at the issue edge
        assign slots[i].insert = issue_now && (alloc_idx == t_tag'(i));

        // A response releases the slot named by its tag
        assign slots[i].free = mem_rsp_valid && (mem_rsp_tag == t_tag'(i));
    end

    // Lowest-numbered idle slot wins, so scan from the top down
    always_comb
    begin
        alloc_ok  = 1'b0;
        alloc_idx = '0;
        for (int i = `WRO_N_SLOTS - 1; i >= 0; i--)
        begin
            if (!busy_mask[i])
            begin
                alloc_ok  = 1'b1;
                alloc_idx = t_tag'(i);
            end
        end
    end

    // ==================================================================
    // Issue toward memory
    // ==================================================================

    // A blocked head stalls everything behind it, keeping program order
    assign issue_now = head.head_valid && (conflict_mask == '0) &&
                       alloc_ok && !mem_almost_full;

    assign head.take = issue_now;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_req_valid <= 1'b0;
        end
        else
        begin
            mem_req_valid <= issue_now;
        end
    end

    // The slot index goes out in place of the client metadata
    always_ff @(posedge clk)
    begin
        if (issue_now)
        begin
            mem_req_is_write <= head.head_is_write;
            mem_req_addr     <= head.head_addr;
            mem_req_tag      <= alloc_idx;
        end
    end

    // ==================================================================
    // Response path
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= mem_rsp_valid;
        end
    end

    // Slot contents are still intact at the edge that frees it
    always_ff @(posedge clk)
    begin
        if (mem_rsp_valid)
        begin
            rsp_is_write <= mem_rsp_is_write;
            rsp_mdata    <= saved_mdata[mem_rsp_tag];
        end
    end

endmodule

// ==== source/wro_top.sv ====
// Write-read ordering shim top level joining hasher, tracking slots and issue
`timescale 1ns/1ps
`include "wro_defines.svh"

module wro_top
(
    input  logic                clk,
    input  logic                reset,

    // Client requests
    input  logic                req_valid,
    input  logic                req_is_write,
    input  wro_req_pkg::t_addr  req_addr,
    input  wro_req_pkg::t_mdata req_mdata,
    output logic                req_almost_full,

    // Requests toward memory
    output logic                mem_req_valid,
    output logic                mem_req_is_write,
    output wro_req_pkg::t_addr  mem_req_addr,
    output wro_req_pkg::t_tag   mem_req_tag,
    input  logic                mem_almost_full,

    // Memory responses
    input  logic                mem_rsp_valid,
    input  logic                mem_rsp_is_write,
    input  wro_req_pkg::t_tag   mem_rsp_tag,

    // Client responses
    output logic                rsp_valid,
    output logic                rsp_is_write,
    output wro_req_pkg::t_mdata rsp_mdata
);

    wro_head_if head_bus ();
    wro_slot_if slot_bus [`WRO_N_SLOTS] ();

    wro_req_hasher hasher_i
    (
        .clk             (clk),
        .reset           (reset),
        .req_valid       (req_valid),
        .req_is_write    (req_is_write),
        .req_addr        (req_addr),
        .req_mdata       (req_mdata),
        .req_almost_full (req_almost_full),
        .head            (head_bus)
    );

    // Every slot watches the same head
    for (genvar i = 0; i < `WRO_N_SLOTS; i++)
    begin : g_slot
        wro_slot slot_i
        (
            .clk   (clk),
            .reset (reset),
            .head  (head_bus),
            .ctl   (slot_bus[i])
        );
    end

    wro_issue issue_i
    (
        .clk              (clk),
        .reset            (reset),
        .head             (head_bus),
        .slots            (slot_bus),
        .mem_almost_full  (mem_almost_full),
        .mem_req_valid    (mem_req_valid),
        .mem_req_is_write (mem_req_is_write),
        .mem_req_addr     (mem_req_addr),
        .mem_req_tag      (mem_req_tag),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp_is_write (mem_rsp_is_write),
        .mem_rsp_tag      (mem_rsp_tag),
        .rsp_valid        (rsp_valid),
        .rsp_is_write     (rsp_is_write),
        .rsp_mdata        (rsp_mdata)
    );

endmodule

// ==== test/wro_chk.sv ====
// Ordering shim protocol assertions, bound into the top level
`timescale 1ns/1ps
`include "wro_defines.svh"

module wro_chk
(
    input logic                clk,
    input logic                reset,
    input logic                mem_almost_full,
    input logic                mem_req_valid,
    input logic                mem_req_is_write,
    input wro_req_pkg::t_addr  mem_req_addr,
    input wro_req_pkg::t_tag   mem_req_tag,
    input logic                mem_rsp_valid,
    input wro_req_pkg::t_tag   mem_rsp_tag,
    input logic                rsp_valid
);
    import wro_req_pkg::*;

    // Per tag, set while a write with that tag is at memory
    logic  write_open [`WRO_N_SLOTS];
    t_hash open_hash  [`WRO_N_SLOTS];
    logic  write_clash;

    // XOR of the address in hash-wide slices, top slice zero-padded
    function automatic t_hash fold_addr(input t_addr a);
        t_hash h;
        h = '0;
        for (int b = 0; b < `WRO_ADDR_BITS; b += `WRO_HASH_BITS)
        begin
            h ^= t_hash'(a >> b);
        end
        return h;
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int t = 0; t < `WRO_N_SLOTS; t++)
            begin
                write_open[t] <= 1'b0;
            end
        end
        else
        begin
            if (mem_rsp_valid)
            begin
                write_open[mem_rsp_tag] <= 1'b0;
            end
            if (mem_req_valid)
            begin
                write_open[mem_req_tag] <= mem_req_is_write;
                open_hash[mem_req_tag]  <= fold_addr(mem_req_addr);
            end
        end
    end

    // A new write must never share its hash with a write still at memory
    always_comb
    begin
        write_clash = 1'b0;
        for (int t = 0; t < `WRO_N_SLOTS; t++)
        begin
            if (mem_req_valid && mem_req_is_write && write_open[t] &&
                (open_hash[t] == fold_addr(mem_req_addr)))
            begin
                write_clash = 1'b1;
            end
        end
    end

    // ==================================================================
    // Assertions
    // ==================================================================

    assert property (@(posedge clk) disable iff (reset) mem_almost_full |=> !mem_req_valid)
        else $error("Memory request issued right after mem_almost_full was high");

    assert property (@(posedge clk) disable iff (reset) mem_rsp_valid |=> rsp_valid)
        else $error("Client response missing one cycle after a memory response");

    assert property (@(posedge clk) disable iff (reset) !mem_rsp_valid |=> !rsp_valid)
        else $error("Client response without a memory response one cycle before");

    assert property (@(posedge clk) disable iff (reset) !write_clash)
        else $error("Two outstanding writes share one address hash");

endmodule

bind wro_top wro_chk chk_i
(
    .clk              (clk),
    .reset            (reset),
    .mem_almost_full  (mem_almost_full),
    .mem_req_valid    (mem_req_valid),
    .mem_req_is_write (mem_req_is_write),
    .mem_req_addr     (mem_req_addr),
    .mem_req_tag      (mem_req_tag),
    .mem_rsp_valid    (mem_rsp_valid),
    .mem_rsp_tag      (mem_rsp_tag),
    .rsp_valid        (rsp_valid)
);

// ==== test/wro_tb.sv ====
// Testbench for the ordering shim with a memory responder and a scoreboard
`timescale 1ns/1ps
`include "wro_defines.svh"

module wro_tb;
    import wro_req_pkg::*;

    localparam int N_REQ   = 31;
    localparam int N_CASES = 5;

    // One client request and the memory delay before its response
    // A delay of zero is replaced by a random one when the table loads
    typedef struct packed
    {
        logic       is_write;
        t_addr      addr;
        t_mdata     mdata;
        logic [7:0] delay;
    } req_row;

    // A run of table rows with the outstanding peak it must reach
    typedef struct packed
    {
        logic [7:0] first;
        logic [7:0] count;
        logic [3:0] min_peak;
        logic [3:0] max_peak;
        logic       expect_af;
        logic [7:0] pressure;
    } case_row;

    logic   clk = 1'b0;
    logic   reset = 1'b1;
    logic   req_valid = 1'b0;
    logic   req_is_write = 1'b0;
    t_addr  req_addr = '0;
    t_mdata req_mdata = '0;
    logic   req_almost_full;
    logic   mem_req_valid;
    logic   mem_req_is_write;
    t_addr  mem_req_addr;
    t_tag   mem_req_tag;
    logic   mem_almost_full = 1'b0;
    logic   mem_rsp_valid = 1'b0;
    logic   mem_rsp_is_write = 1'b0;
    t_tag   mem_rsp_tag = '0;
    logic   rsp_valid;
    logic   rsp_is_write;
    t_mdata rsp_mdata;

    req_row  reqs      [N_REQ];
    case_row cases     [N_CASES];
    string   case_name [N_CASES];

    // Scoreboard view of what is at memory, indexed by tag
    logic    out_valid [`WRO_N_SLOTS] = '{default: 1'b0};
    logic    out_write [`WRO_N_SLOTS];
    t_hash   out_hash  [`WRO_N_SLOTS];
    t_mdata  out_mdata [`WRO_N_SLOTS];

    // Responder queue of issued tags and the cycle each one is due
    int      pend_tag   [$];
    int      pend_due   [$];
    logic    pend_write [$];

    int      cycle = 0;
    int      press_until = 0;
    int      next_issue = 0;
    int      n_open = 0;
    int      done_count = 0;
    int      peak = 0;
    int      errors = 0;
    logic    af_seen = 1'b0;
    logic    af_prev = 1'b0;
    logic    rsp_due = 1'b0;
    t_tag    rsp_tag_q = '0;

    wro_top dut_i
    (
        .clk              (clk),
        .reset            (reset),
        .req_valid        (req_valid),
        .req_is_write     (req_is_write),
        .req_addr         (req_addr),
        .req_mdata        (req_mdata),
        .req_almost_full  (req_almost_full),
        .mem_req_valid    (mem_req_valid),
        .mem_req_is_write (mem_req_is_write),
        .mem_req_addr     (mem_req_addr),
        .mem_req_tag      (mem_req_tag),
        .mem_almost_full  (mem_almost_full),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp_is_write (mem_rsp_is_write),
        .mem_rsp_tag      (mem_rsp_tag),
        .rsp_valid        (rsp_valid),
        .rsp_is_write     (rsp_is_write),
        .rsp_mdata        (rsp_mdata)
    );

    initial
    begin
        forever
        begin
            #5 clk = ~clk;
        end
    end

    // Fifty cycles per table row is far beyond the slowest case
    initial
    begin
        repeat (N_REQ * 50) @(posedge clk);
        $display("Watchdog expired with %0d of %0d responses received", done_count, N_REQ);
        $display("test failed");
        $finish;
    end

    // ==================================================================
    // Helpers
    // ==================================================================

    // XOR of the address in hash-wide slices, top slice zero-padded
    function automatic t_hash fold_addr(input t_addr a);
        t_hash h;
        h = '0;
        for (int b = 0; b < `WRO_ADDR_BITS; b += `WRO_HASH_BITS)
        begin
            h ^= t_hash'(a >> b);
        end
        return h;
    endfunction

    task automatic flag_error(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    // Hashes 0x1000, 0x1 and 0x40 all fold to 1, so they collide
    task automatic load_tables();
        reqs[0]  = '{1'b0, 32'h0000_0010, 16'ha001, 8'd3};
        reqs[1]  = '{1'b1, 32'h0000_0021, 16'ha002, 8'd5};
        reqs[2]  = '{1'b0, 32'h0000_0032, 16'ha003, 8'd0};
        reqs[3]  = '{1'b1, 32'h0000_1000, 16'hb001, 8'd20};
        reqs[4]  = '{1'b1, 32'h0000_0001, 16'hb002, 8'd4};
        reqs[5]  = '{1'b0, 32'h0000_0040, 16'hb003, 8'd15};
        reqs[6]  = '{1'b1, 32'h0000_1000, 16'hb004, 8'd3};
        reqs[7]  = '{1'b0, 32'h0000_0005, 16'hb005, 8'd2};
        reqs[8]  = '{1'b1, 32'h0000_0007, 16'hc001, 8'd10};
        reqs[9]  = '{1'b0, 32'h0000_0007, 16'hc002, 8'd6};
        reqs[10] = '{1'b0, 32'h0000_0007, 16'hc003, 8'd6};
        reqs[11] = '{1'b0, 32'h0000_0007, 16'hc004, 8'd6};
        reqs[12] = '{1'b0, 32'h0000_0008, 16'hc005, 8'd0};
        reqs[13] = '{1'b1, 32'h0000_0011, 16'hd001, 8'd0};
        reqs[14] = '{1'b0, 32'h0000_0012, 16'hd002, 8'd0};
        reqs[15] = '{1'b1, 32'h0000_0013, 16'hd003, 8'd0};
        reqs[16] = '{1'b0, 32'h0000_0014, 16'hd004, 8'd0};
        reqs[17] = '{1'b1, 32'h0000_0015, 16'hd005, 8'd0};
        reqs[18] = '{1'b0, 32'h0000_0016, 16'hd006, 8'd0};
        reqs[19] = '{1'b1, 32'h0000_0017, 16'hd007, 8'd0};
        reqs[20] = '{1'b0, 32'h0000_0011, 16'hd008, 8'd0};
        reqs[21] = '{1'b1, 32'h0000_0019, 16'hd009, 8'd0};
        for (int i = 0; i < 9; i++)
        begin
            reqs[22 + i] = '{i[0], 32'h21 + i, 16'he001 + 16'(i), 8'd30};
        end
        // Rows without a fixed delay draw one from the seeded stream
        for (int i = 0; i < N_REQ; i++)
        begin
            if (reqs[i].delay == 8'd0)
            begin
                reqs[i].delay = 8'(1 + $urandom % 12);
            end
        end
        cases[0] = '{8'd0, 8'd3, 4'd1, 4'd8, 1'b0, 8'd0};
        cases[1] = '{8'd3, 8'd5, 4'd1, 4'd2, 1'b0, 8'd0};
        cases[2] = '{8'd8, 8'd5, 4'd3, 4'd8, 1'b0, 8'd0};
        cases[3] = '{8'd13, 8'd9, 4'd1, 4'd8, 1'b0, 8'd0};
        cases[4] = '{8'd22, 8'd9, 4'd8, 4'd8, 1'b1, 8'd20};
        case_name[0] = "reset and metadata";
        case_name[1] = "hash collisions";
        case_name[2] = "read ordering";
        case_name[3] = "order and tag reuse";
        case_name[4] = "memory back-pressure";
    endtask

    // Check room at the falling edge, then strobe one request
    task automatic send_request(input req_row row);
        @(negedge clk);
        while (req_almost_full)
        begin
            @(posedge clk);
            req_valid <= 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        req_valid    <= 1'b1;
        req_is_write <= row.is_write;
        req_addr     <= row.addr;
        req_mdata    <= row.mdata;
    endtask

    // ==================================================================
    // Memory responder
    // ==================================================================

    // Oldest due tag answers first, one response per cycle
    always @(posedge clk)
    begin : respond
        int pick;
        pick = -1;
        mem_almost_full <= (cycle < press_until);
        mem_rsp_valid   <= 1'b0;
        for (int i = 0; i < pend_tag.size(); i++)
        begin
            if (pick < 0 && pend_due[i] <= cycle)
            begin
                pick = i;
            end
        end
        if (pick >= 0)
        begin
            mem_rsp_valid    <= 1'b1;
            mem_rsp_tag      <= t_tag'(pend_tag[pick]);
            mem_rsp_is_write <= pend_write[pick];
            pend_tag.delete(pick);
            pend_due.delete(pick);
            pend_write.delete(pick);
        end
    end

    // ==================================================================
    // Scoreboard, sampled at the falling edge where outputs are stable
    // ==================================================================

    always @(negedge clk)
    begin : monitor
        t_hash  h;
        req_row row;
        cycle++;
        if (!reset)
        begin
            af_seen = af_seen | req_almost_full;
            if (mem_req_valid && next_issue >= N_REQ)
            begin
                flag_error("memory request beyond the end of the table");
            end
            else if (mem_req_valid)
            begin
                row = reqs[next_issue];
                h   = fold_addr(row.addr);
                assert (!af_prev)
                    else flag_error("mem_req_valid right after mem_almost_full");
                assert (mem_req_addr == row.addr && mem_req_is_write == row.is_write)
                    else flag_error($sformatf("request %0d out of order, addr %h",
                                              next_issue, mem_req_addr));
                assert (!out_valid[mem_req_tag])
                    else flag_error($sformatf("tag %0d reused while pending", mem_req_tag));
                // A write waits on any same-hash request, a read only on a write
                for (int t = 0; t < `WRO_N_SLOTS; t++)
                begin
                    assert (!(out_valid[t] && out_hash[t] == h &&
                              (out_write[t] || row.is_write)))
                        else flag_error($sformatf("request %0d issued over tag %0d",
                                                  next_issue, t));
                end
                out_valid[mem_req_tag] = 1'b1;
                out_write[mem_req_tag] = row.is_write;
                out_hash[mem_req_tag]  = h;
                out_mdata[mem_req_tag] = row.mdata;
                pend_tag.push_back(int'(mem_req_tag));
                pend_write.push_back(row.is_write);
                pend_due.push_back(cycle + int'(row.delay));
                next_issue++;
                n_open++;
                if (n_open > peak)
                begin
                    peak = n_open;
                end
            end
            // The response is owed exactly one cycle after mem_rsp_valid
            if (rsp_due)
            begin
                assert (rsp_valid && rsp_mdata == out_mdata[rsp_tag_q] &&
                        rsp_is_write == out_write[rsp_tag_q])
                    else flag_error($sformatf("tag %0d response valid %b mdata %h, expected %h",
                                              rsp_tag_q, rsp_valid, rsp_mdata,
                                              out_mdata[rsp_tag_q]));
                out_valid[rsp_tag_q] = 1'b0;
                n_open--;
                done_count++;
            end
            else
            begin
                assert (!rsp_valid)
                    else flag_error("rsp_valid without a memory response");
            end
            rsp_due   = mem_rsp_valid;
            rsp_tag_q = mem_rsp_tag;
            af_prev   = mem_almost_full;
        end
    end

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial
    begin
        int errs_before;
        int n_pass;
        void'($urandom(32'h22e4));
        n_pass = 0;
        load_tables();
        repeat (7) @(posedge clk);
        @(negedge clk);
        assert (!req_almost_full && !mem_req_valid && !rsp_valid)
            else flag_error("outputs not low after reset");
        @(posedge clk);
        reset <= 1'b0;

        for (int c = 0; c < N_CASES; c++)
        begin
            @(posedge clk);
            errs_before = errors;
            peak        = 0;
            af_seen     = 1'b0;
            press_until <= cycle + int'(cases[c].pressure);
            for (int r = cases[c].first; r < cases[c].first + cases[c].count; r++)
            begin
                send_request(reqs[r]);
            end
            @(posedge clk);
            req_valid <= 1'b0;
            while (done_count < cases[c].first + cases[c].count)
            begin
                @(posedge clk);
            end
            assert (peak >= cases[c].min_peak && peak <= cases[c].max_peak)
                else flag_error($sformatf("peak of %0d outstanding, expected %0d to %0d",
                                          peak, cases[c].min_peak, cases[c].max_peak));
            assert (af_seen || !cases[c].expect_af)
                else flag_error("req_almost_full never rose under memory back-pressure");
            if (errors == errs_before)
            begin
                $display("case %0d %s: ok", c, case_name[c]);
                n_pass++;
            end
            else
            begin
                $display("case %0d %s: %0d errors", c, case_name[c], errors - errs_before);
            end
        end

        $display("cases %0d, passed %0d, failed %0d, errors %0d",
                 N_CASES, n_pass, N_CASES - n_pass, errors);
        if (errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+source
source/wro_req_pkg.sv
source/wro_ctrl_pkg.sv
source/wro_head_if.sv
source/wro_slot_if.sv
source/wro_req_hasher.sv
source/wro_slot.sv
source/wro_issue.sv
source/wro_top.sv
test/wro_chk.sv
test/wro_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the write-read ordering shim testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module wro_tb -f flist.f -o wro_sim

./obj_dir/wro_sim | tee sim.log

if grep -q "^test passed$" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi
